// ==== verilog/rv32i_pkg.sv ====
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  reg_idx_t;

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_t;

    // where an operand is taken from
    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // decoded fields, imm already chosen by format
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        rv32i_word  imm;
    } instr_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    load_regfile;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    is_jump;
        logic    link;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        rv32i_word pc;
        rv32i_word instr;
    } ifid_t;

    typedef struct packed {
        logic      valid;
        rv32i_word pc;
        instr_t    instr;
        ctrl_t     ctrl;
        rv32i_word rs1_val;
        rv32i_word rs2_val;
    } idex_t;

    typedef struct packed {
        logic      valid;
        rv32i_word pc;
        instr_t    instr;
        ctrl_t     ctrl;
        rv32i_word alu_out;
        rv32i_word store_data;
        logic      br_taken;
    } exmem_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        reg_idx_t  rd;
        rv32i_word wb_val;
    } memwb_t;

endpackage : rv32i_pkg

// ==== verilog/fetch_stage.sv ====
module fetch_stage import rv32i_pkg::*; #(
    parameter rv32i_word reset_pc = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      branch_rst,
    input  logic      freeze,
    input  logic      load_stall,
    input  logic      redirect_valid,
    input  rv32i_word redirect_pc,
    input  rv32i_word icache_rdata,
    output logic      icache_read,
    output rv32i_word icache_addr,
    output ifid_t     ifid
);

    rv32i_word pc;
    rv32i_word pc_next;
    logic      fetch_en;

    // redirect from memory wins over sequential fetch
    assign pc_next = redirect_valid ? redirect_pc : pc + 32'd4;

    // request every cycle once out of reset
    assign icache_read = fetch_en;
    assign icache_addr = pc;

    always_ff @(posedge clk) begin
        if (branch_rst) begin
            pc         <= reset_pc;
            fetch_en   <= 1'b0;
            ifid.valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            // nothing was requested in the cycle that leaves reset
            if (fetch_en && !freeze) begin
                if (redirect_valid) begin
                    pc         <= pc_next;
                    ifid.valid <= 1'b0;
                end else if (!load_stall) begin
                    pc         <= pc_next;
                    ifid.valid <= 1'b1;
                    ifid.pc    <= pc;
                    ifid.instr <= icache_rdata;
                end
            end
        end
    end

    // jump and branch targets from execute must stay on word boundaries
    pc_aligned: assert property (@(posedge clk) disable iff (branch_rst)
        pc[1:0] == 2'b00);

endmodule : fetch_stage

// ==== verilog/decode_stage.sv ====
module decode_stage import rv32i_pkg::*; (
    input  logic   clk,
    input  logic   branch_rst,
    input  logic   freeze,
    input  logic   load_stall,
    input  logic   redirect_valid,
    input  ifid_t  ifid,
    input  memwb_t memwb,
    output instr_t id_srcs,
    output idex_t  idex
);

    rv32i_word regs [1:31];
    rv32i_word raw;
    instr_t    dec;
    ctrl_t     ctrl;
    logic      known;
    logic      id_valid;
    logic      wb_en;
    logic      bubble;

    function automatic alu_op_t alu_decode(logic [2:0] funct3, logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b101:  return alu_srl;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    // x0 reads zero, a same-cycle writeback is seen first
    function automatic rv32i_word rf_read(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en && memwb.rd == idx) begin
            return memwb.wb_val;
        end
        return regs[idx];
    endfunction

    assign raw = ifid.instr;

    always_comb begin
        dec.opcode = opcode_t'(raw[6:0]);
        dec.rd     = raw[11:7];
        dec.funct3 = raw[14:12];
        dec.rs1    = raw[19:15];
        dec.rs2    = raw[24:20];
        dec.imm    = '0;
        ctrl       = '0;
        known      = 1'b1;
        case (dec.opcode)
            op_reg: begin
                ctrl.alu_op       = alu_decode(dec.funct3, raw[30]);
                ctrl.load_regfile = 1'b1;
            end
            op_imm: begin
                dec.rs2           = '0;
                dec.imm           = {{20{raw[31]}}, raw[31:20]};
                ctrl.alu_op       = alu_decode(dec.funct3, 1'b0);
                ctrl.use_imm      = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            op_lui: begin
                dec.rs1           = '0;
                dec.rs2           = '0;
                dec.imm           = {raw[31:12], 12'h000};
                ctrl.load_regfile = 1'b1;
            end
            op_load: begin
                dec.rs2           = '0;
                dec.imm           = {{20{raw[31]}}, raw[31:20]};
                ctrl.use_imm      = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read     = 1'b1;
            end
            op_store: begin
                dec.imm        = {{20{raw[31]}}, raw[31:25], raw[11:7]};
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_br: begin
                dec.imm        = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
                ctrl.is_branch = 1'b1;
            end
            op_jal: begin
                dec.rs1           = '0;
                dec.rs2           = '0;
                dec.imm           = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
                ctrl.is_jump      = 1'b1;
                ctrl.link         = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            default: begin
                known = 1'b0;
            end
        endcase
        // bubbles carry no sources and no control
        if (!ifid.valid || !known) begin
            dec.rs1 = '0;
            dec.rs2 = '0;
            ctrl    = '0;
        end
    end

    assign id_valid = ifid.valid && known;
    assign id_srcs  = dec;

    assign wb_en = memwb.valid && memwb.ctrl.load_regfile && memwb.rd != '0;

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[memwb.rd] <= memwb.wb_val;
        end
    end

    assign bubble = load_stall || redirect_valid || !id_valid;

    always_ff @(posedge clk) begin
        if (branch_rst) begin
            idex.valid <= 1'b0;
            idex.ctrl  <= '0;
        end else if (!freeze) begin
            if (bubble) begin
                idex.valid <= 1'b0;
                idex.ctrl  <= '0;
            end else begin
                idex.valid <= 1'b1;
                idex.ctrl  <= ctrl;
            end
            idex.pc      <= ifid.pc;
            idex.instr   <= dec;
            idex.rs1_val <= rf_read(dec.rs1);
            idex.rs2_val <= rf_read(dec.rs2);
        end
    end

endmodule : decode_stage

// ==== verilog/hazard_unit.sv ====
module hazard_unit import rv32i_pkg::*; (
    input  instr_t   id_srcs,
    input  idex_t    idex,
    input  exmem_t   exmem,
    input  memwb_t   memwb,
    input  logic     icache_read,
    input  logic     icache_resp,
    input  logic     dcache_read,
    input  logic     dcache_write,
    input  logic     dcache_resp,
    output fwd_sel_t rs1_sel,
    output fwd_sel_t rs2_sel,
    output fwd_sel_t store_sel,
    output logic     load_stall,
    output logic     freeze
);

    logic mem_writes;
    logic wb_writes;
    logic ex_is_load;

    // only producers of a nonzero register can forward
    assign mem_writes = exmem.valid && exmem.ctrl.load_regfile && exmem.instr.rd != '0;
    assign wb_writes  = memwb.valid && memwb.ctrl.load_regfile && memwb.rd != '0;

    // memory holds the younger producer so it is checked first
    function automatic fwd_sel_t src_sel(reg_idx_t src);
        if (mem_writes && exmem.instr.rd == src) begin
            return fwd_mem;
        end
        if (wb_writes && memwb.rd == src) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    always_comb begin
        rs1_sel = src_sel(idex.instr.rs1);
        rs2_sel = src_sel(idex.instr.rs2);
        // store data in memory can still pick up the writeback value
        if (exmem.ctrl.mem_write && wb_writes && memwb.rd == exmem.instr.rs2) begin
            store_sel = fwd_wb;
        end else begin
            store_sel = fwd_reg;
        end
    end

    assign ex_is_load = idex.valid && idex.ctrl.mem_read && idex.instr.rd != '0;
    assign load_stall = ex_is_load &&
                        (idex.instr.rd == id_srcs.rs1 || idex.instr.rd == id_srcs.rs2);

    // any outstanding request without resp holds the whole pipe
    assign freeze = (icache_read && !icache_resp) ||
                    ((dcache_read || dcache_write) && !dcache_resp);

endmodule : hazard_unit

// ==== verilog/execute_stage.sv ====
module execute_stage import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      branch_rst,
    input  logic      freeze,
    input  logic      redirect_valid,
    input  idex_t     idex,
    input  fwd_sel_t  rs1_sel,
    input  fwd_sel_t  rs2_sel,
    input  rv32i_word exmem_fwd,
    input  rv32i_word wb_fwd,
    output exmem_t    exmem
);

    rv32i_word op_a;
    rv32i_word op_b;
    rv32i_word alu_b;
    rv32i_word alu_res;
    rv32i_word target;
    rv32i_word ex_result;
    logic      taken;

    function automatic rv32i_word pick(fwd_sel_t sel, rv32i_word reg_val);
        case (sel)
            fwd_mem: return exmem_fwd;
            fwd_wb:  return wb_fwd;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a  = pick(rs1_sel, idex.rs1_val);
        op_b  = pick(rs2_sel, idex.rs2_val);
        alu_b = idex.ctrl.use_imm ? idex.instr.imm : op_b;
    end

    always_comb begin
        case (idex.ctrl.alu_op)
            alu_add: alu_res = op_a + alu_b;
            alu_sub: alu_res = op_a - alu_b;
            alu_and: alu_res = op_a & alu_b;
            alu_or:  alu_res = op_a | alu_b;
            alu_xor: alu_res = op_a ^ alu_b;
            alu_slt: alu_res = {31'b0, $signed(op_a) < $signed(alu_b)};
            alu_sll: alu_res = op_a << alu_b[4:0];
            alu_srl: alu_res = op_a >> alu_b[4:0];
            default: alu_res = op_a + alu_b;
        endcase
    end

    // branches and jal share the pc-relative adder
    assign target = idex.pc + idex.instr.imm;

    assign ex_result = (idex.instr.opcode == op_lui) ? idex.instr.imm :
                       (idex.ctrl.is_branch || idex.ctrl.is_jump) ? target : alu_res;

    // beq on funct3 000, bne on 001
    assign taken = idex.ctrl.is_branch &&
                   ((idex.instr.funct3 == 3'b000 && op_a == op_b) ||
                    (idex.instr.funct3 == 3'b001 && op_a != op_b));

    always_ff @(posedge clk) begin
        if (branch_rst) begin
            exmem.valid    <= 1'b0;
            exmem.ctrl     <= '0;
            exmem.br_taken <= 1'b0;
        end else if (!freeze) begin
            if (redirect_valid) begin
                exmem.valid    <= 1'b0;
                exmem.ctrl     <= '0;
                exmem.br_taken <= 1'b0;
            end else begin
                exmem.valid    <= idex.valid;
                exmem.ctrl     <= idex.ctrl;
                exmem.br_taken <= taken;
            end
            exmem.pc         <= idex.pc;
            exmem.instr      <= idex.instr;
            exmem.alu_out    <= ex_result;
            exmem.store_data <= op_b;
        end
    end

    // a load in memory has no data yet, the load-use stall keeps its consumer back
    no_load_fwd: assert property (@(posedge clk) disable iff (branch_rst)
        (idex.valid && exmem.valid && exmem.ctrl.mem_read)
            |-> (rs1_sel != fwd_mem && rs2_sel != fwd_mem));

endmodule : execute_stage

// ==== verilog/memory_stage.sv ====
module memory_stage import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       branch_rst,
    input  logic       freeze,
    input  exmem_t     exmem,
    input  fwd_sel_t   store_sel,
    input  rv32i_word  wb_fwd,
    input  rv32i_word  dcache_rdata,
    output logic       dcache_read,
    output logic       dcache_write,
    output rv32i_word  dcache_addr,
    output rv32i_word  dcache_wdata,
    output logic [3:0] dcache_byte_enable,
    output logic       redirect_valid,
    output rv32i_word  redirect_pc,
    output memwb_t     memwb
);

    rv32i_word wb_val;

    assign dcache_read  = exmem.valid && exmem.ctrl.mem_read;
    assign dcache_write = exmem.valid && exmem.ctrl.mem_write;
    assign dcache_addr  = exmem.alu_out;
    assign dcache_wdata = (store_sel == fwd_wb) ? wb_fwd : exmem.store_data;
    // word stores only
    assign dcache_byte_enable = {4{dcache_write}};

    // taken branch or jal, target already in alu_out
    assign redirect_valid = exmem.valid && (exmem.br_taken || exmem.ctrl.is_jump);
    assign redirect_pc    = exmem.alu_out;

    assign wb_val = exmem.ctrl.mem_read ? dcache_rdata :
                    exmem.ctrl.link ? exmem.pc + 32'd4 : exmem.alu_out;

    always_ff @(posedge clk) begin
        if (branch_rst) begin
            memwb.valid <= 1'b0;
            memwb.ctrl  <= '0;
        end else if (!freeze) begin
            memwb.valid  <= exmem.valid;
            memwb.ctrl   <= exmem.ctrl;
            memwb.rd     <= exmem.instr.rd;
            memwb.wb_val <= wb_val;
        end
    end

    rw_exclusive: assert property (@(posedge clk) disable iff (branch_rst)
        !(dcache_read && dcache_write));

endmodule : memory_stage

// ==== verilog/datapath.sv ====
module datapath import rv32i_pkg::*; #(
    parameter rv32i_word reset_pc = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       branch_rst,

    // icache port
    output logic       icache_read,
    output rv32i_word  icache_addr,
    input  rv32i_word  icache_rdata,
    input  logic       icache_resp,

    // dcache port
    output logic [3:0] dcache_byte_enable,
    output logic       dcache_read,
    output logic       dcache_write,
    output rv32i_word  dcache_addr,
    output rv32i_word  dcache_wdata,
    input  rv32i_word  dcache_rdata,
    input  logic       dcache_resp
);

    ifid_t     ifid;
    idex_t     idex;
    exmem_t    exmem;
    memwb_t    memwb;
    instr_t    id_srcs;
    fwd_sel_t  rs1_sel;
    fwd_sel_t  rs2_sel;
    fwd_sel_t  store_sel;
    logic      load_stall;
    logic      freeze;
    logic      redirect_valid;
    rv32i_word redirect_pc;

    fetch_stage #(
        .reset_pc       (reset_pc)
    ) fetch (
        .clk            (clk),
        .branch_rst     (branch_rst),
        .freeze         (freeze),
        .load_stall     (load_stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .icache_rdata   (icache_rdata),
        .icache_read    (icache_read),
        .icache_addr    (icache_addr),
        .ifid           (ifid)
    );

    decode_stage decode (
        .clk            (clk),
        .branch_rst     (branch_rst),
        .freeze         (freeze),
        .load_stall     (load_stall),
        .redirect_valid (redirect_valid),
        .ifid           (ifid),
        .memwb          (memwb),
        .id_srcs        (id_srcs),
        .idex           (idex)
    );

    hazard_unit hazard (
        .id_srcs        (id_srcs),
        .idex           (idex),
        .exmem          (exmem),
        .memwb          (memwb),
        .icache_read    (icache_read),
        .icache_resp    (icache_resp),
        .dcache_read    (dcache_read),
        .dcache_write   (dcache_write),
        .dcache_resp    (dcache_resp),
        .rs1_sel        (rs1_sel),
        .rs2_sel        (rs2_sel),
        .store_sel      (store_sel),
        .load_stall     (load_stall),
        .freeze         (freeze)
    );

    // a jal in memory is always flushing execute, so alu_out is the only mem result needed
    execute_stage execute (
        .clk            (clk),
        .branch_rst     (branch_rst),
        .freeze         (freeze),
        .redirect_valid (redirect_valid),
        .idex           (idex),
        .rs1_sel        (rs1_sel),
        .rs2_sel        (rs2_sel),
        .exmem_fwd      (exmem.alu_out),
        .wb_fwd         (memwb.wb_val),
        .exmem          (exmem)
    );

    memory_stage memory (
        .clk                (clk),
        .branch_rst         (branch_rst),
        .freeze             (freeze),
        .exmem              (exmem),
        .store_sel          (store_sel),
        .wb_fwd             (memwb.wb_val),
        .dcache_rdata       (dcache_rdata),
        .dcache_read        (dcache_read),
        .dcache_write       (dcache_write),
        .dcache_addr        (dcache_addr),
        .dcache_wdata       (dcache_wdata),
        .dcache_byte_enable (dcache_byte_enable),
        .redirect_valid     (redirect_valid),
        .redirect_pc        (redirect_pc),
        .memwb              (memwb)
    );

endmodule : datapath

// ==== verification/cache_model.sv ====
module cache_model import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       branch_rst,
    input  logic       icache_read,
    input  rv32i_word  icache_addr,
    output rv32i_word  icache_rdata,
    output logic       icache_resp,
    input  logic       dcache_read,
    input  logic       dcache_write,
    input  rv32i_word  dcache_addr,
    input  rv32i_word  dcache_wdata,
    input  logic [3:0] dcache_byte_enable,
    output rv32i_word  dcache_rdata,
    output logic       dcache_resp
);

    timeunit 1ns;
    timeprecision 1ps;

    rv32i_word imem [256];
    rv32i_word dmem [256];
    integer    seed = 32'ha6ac_d56f;
    int        i_left = 0;
    int        d_left = 0;
    logic      i_busy = 1'b0;
    logic      d_busy = 1'b0;
    rv32i_word i_rdata = '0;
    rv32i_word d_rdata = '0;
    logic      i_resp = 1'b0;
    logic      d_resp = 1'b0;

    assign icache_rdata = i_rdata;
    assign icache_resp  = i_resp;
    assign dcache_rdata = d_rdata;
    assign dcache_resp  = d_resp;

    // response delay of 0 to 3 cycles
    function automatic int draw_delay();
        integer r;
        r = $random(seed);
        return int'(r[1:0]);
    endfunction

    // unknown opcodes outside the program, data tagged with its index
    initial begin
        for (int k = 0; k < 256; k++) begin
            imem[k] = {17'h0, 8'(k), 7'h00};
            dmem[k] = {16'hd00d, 8'h00, 8'(k)};
        end
    end

    always @(negedge clk) begin
        if (branch_rst || !icache_read) begin
            i_busy = 1'b0;
            i_resp = 1'b0;
        end else begin
            if (!i_busy) begin
                i_left = draw_delay();
                i_busy = 1'b1;
            end else begin
                i_left = i_left - 1;
            end
            if (i_left == 0) begin
                i_busy  = 1'b0;
                i_resp  = 1'b1;
                i_rdata = imem[icache_addr[9:2]];
            end else begin
                i_resp = 1'b0;
            end
        end

        if (branch_rst || !(dcache_read || dcache_write)) begin
            d_busy = 1'b0;
            d_resp = 1'b0;
        end else begin
            if (!d_busy) begin
                d_left = draw_delay();
                d_busy = 1'b1;
            end else begin
                d_left = d_left - 1;
            end
            if (d_left == 0) begin
                d_busy = 1'b0;
                d_resp = 1'b1;
                if (dcache_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (dcache_byte_enable[b]) begin
                            dmem[dcache_addr[9:2]][8*b +: 8] = dcache_wdata[8*b +: 8];
                        end
                    end
                end else begin
                    d_rdata = dmem[dcache_addr[9:2]];
                end
            end else begin
                d_resp = 1'b0;
            end
        end
    end

endmodule : cache_model

// ==== verification/datapath_tb.sv ====
module datapath_tb import rv32i_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        rv32i_word addr;
        rv32i_word data;
    } store_t;

    localparam int n_prog   = 30;
    localparam int n_stores = 9;
    localparam int timeout_cycles = 300;
    localparam int quiet_cycles   = 60;
    localparam rv32i_word start_pc = 32'h0000_0000;

    localparam rv32i_word prog [n_prog] = '{
        32'h00500093,  // 00 addi x1, x0, 5
        32'h00700113,  // 04 addi x2, x0, 7
        32'h002081b3,  // 08 add  x3, x1, x2
        32'h40118233,  // 0c sub  x4, x3, x1
        32'h003242b3,  // 10 xor  x5, x4, x3
        32'h10502023,  // 14 sw   x5, 0x100(x0)
        32'h10302223,  // 18 sw   x3, 0x104(x0)
        32'h10002303,  // 1c lw   x6, 0x100(x0)
        32'h001303b3,  // 20 add  x7, x6, x1
        32'h10702423,  // 24 sw   x7, 0x108(x0)
        32'h123454b7,  // 28 lui  x9, 0x12345
        32'hfff00513,  // 2c addi x10, x0, -1
        32'h10902623,  // 30 sw   x9, 0x10c(x0)
        32'h001525b3,  // 34 slt  x11, x10, x1
        32'h00b4d633,  // 38 srl  x12, x9, x11
        32'h10c02823,  // 3c sw   x12, 0x110(x0)
        32'h10b02a23,  // 40 sw   x11, 0x114(x0)
        32'h00108863,  // 44 beq  x1, x1, +16
        32'h1e102823,  // 48 sw   x1, 0x1f0(x0)
        32'h1e102a23,  // 4c sw   x1, 0x1f4(x0)
        32'h1e102c23,  // 50 sw   x1, 0x1f8(x0)
        32'h00109463,  // 54 bne  x1, x1, +8
        32'h10202c23,  // 58 sw   x2, 0x118(x0)
        32'h00c0076f,  // 5c jal  x14, +12
        32'h1e102e23,  // 60 sw   x1, 0x1fc(x0)
        32'h1e102623,  // 64 sw   x1, 0x1ec(x0)
        32'h10e02e23,  // 68 sw   x14, 0x11c(x0)
        32'h00471793,  // 6c slli x15, x14, 4
        32'h12f02023,  // 70 sw   x15, 0x120(x0)
        32'h0000006f   // 74 jal  x0, 0
    };

    // stores in program order, skipped ones never appear
    localparam store_t expected [n_stores] = '{
        '{32'h0000_0100, 32'h0000_000b},
        '{32'h0000_0104, 32'h0000_000c},
        '{32'h0000_0108, 32'h0000_0010},
        '{32'h0000_010c, 32'h1234_5000},
        '{32'h0000_0110, 32'h091a_2800},
        '{32'h0000_0114, 32'h0000_0001},
        '{32'h0000_0118, 32'h0000_0007},
        '{32'h0000_011c, 32'h0000_0060},
        '{32'h0000_0120, 32'h0000_0600}
    };

    logic       clk;
    logic       branch_rst;
    logic       icache_read;
    rv32i_word  icache_addr;
    rv32i_word  icache_rdata;
    logic       icache_resp;
    logic [3:0] dcache_byte_enable;
    logic       dcache_read;
    logic       dcache_write;
    rv32i_word  dcache_addr;
    rv32i_word  dcache_wdata;
    rv32i_word  dcache_rdata;
    logic       dcache_resp;

    datapath #(
        .reset_pc (start_pc)
    ) dut (
        .clk                (clk),
        .branch_rst         (branch_rst),
        .icache_read        (icache_read),
        .icache_addr        (icache_addr),
        .icache_rdata       (icache_rdata),
        .icache_resp        (icache_resp),
        .dcache_byte_enable (dcache_byte_enable),
        .dcache_read        (dcache_read),
        .dcache_write       (dcache_write),
        .dcache_addr        (dcache_addr),
        .dcache_wdata       (dcache_wdata),
        .dcache_rdata       (dcache_rdata),
        .dcache_resp        (dcache_resp)
    );

    cache_model cache (
        .clk                (clk),
        .branch_rst         (branch_rst),
        .icache_read        (icache_read),
        .icache_addr        (icache_addr),
        .icache_rdata       (icache_rdata),
        .icache_resp        (icache_resp),
        .dcache_read        (dcache_read),
        .dcache_write       (dcache_write),
        .dcache_addr        (dcache_addr),
        .dcache_wdata       (dcache_wdata),
        .dcache_byte_enable (dcache_byte_enable),
        .dcache_rdata       (dcache_rdata),
        .dcache_resp        (dcache_resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // a store retires only in a cycle where the pipe is not frozen by the icache
    function automatic logic store_done();
        return dcache_write && dcache_resp && (!icache_read || icache_resp);
    endfunction

    // outputs are settled between the cache update at negedge and the next posedge
    task automatic wait_sample_point();
        @(negedge clk);
        #5;
    endtask

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, rv32i_word got, rv32i_word exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_data(rv32i_word got, rv32i_word exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED dcache_wdata: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_byte_enable(logic [3:0] got, logic [3:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED dcache_byte_enable: got %h expected %h",
                                    got, exp));
        end
    endtask

    initial begin
        int   cycles;
        logic seen;
        branch_rst = 1'b1;
        @(negedge clk);
        for (int i = 0; i < n_prog; i++) begin
            cache.imem[i] = prog[i];
        end
        @(negedge clk);
        branch_rst = 1'b0;

        // state left by reset, no request issued yet
        #5;
        check_flag("icache_read", icache_read, 1'b0);
        check_addr("icache_addr", icache_addr, start_pc);
        check_flag("dcache_read", dcache_read, 1'b0);
        check_flag("dcache_write", dcache_write, 1'b0);

        // first cycle after reset fetches from the reset address
        wait_sample_point();
        check_flag("icache_read", icache_read, 1'b1);
        check_addr("icache_addr", icache_addr, start_pc);

        for (int s = 0; s < n_stores; s++) begin
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < timeout_cycles) begin
                wait_sample_point();
                if (store_done()) begin
                    seen = 1'b1;
                end else begin
                    cycles++;
                end
            end
            if (!seen) begin
                stop_on_error($sformatf("no store %0d seen within %0d cycles", s,
                                        timeout_cycles));
            end
            check_addr("dcache_addr", dcache_addr, expected[s].addr);
            check_data(dcache_wdata, expected[s].data);
            check_byte_enable(dcache_byte_enable, 4'hf);
        end

        // program now spins on its final jal
        for (int c = 0; c < quiet_cycles; c++) begin
            wait_sample_point();
            if (store_done()) begin
                stop_on_error($sformatf("unexpected store to %h after the final store",
                                        dcache_addr));
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule : datapath_tb

// ==== sources.f ====
verilog/rv32i_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/datapath.sv
verification/cache_model.sv
verification/datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f --top-module datapath_tb -o datapath_sim; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/datapath_sim > "$LOG" 2>&1; then
    echo "simulator returned an error status"
fi

cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi

if ! grep -q "all tests passed" "$LOG"; then
    echo "FAIL: no verdict in log"
    exit 1
fi

echo "PASS"
exit 0
